//--- mips_front_top.f
rtl/mips_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/registers_bank.sv
rtl/control_unit.sv
rtl/fetch_unit.sv
rtl/id_stage.sv
rtl/mips_front_top.sv
tests/mips_front_top_tb.sv

//--- rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire                           i_enable,   // Low means bubble
    input  wire  mips_isa_pkg::opcode_e   i_opcode,
    output pipe_pkg::ctrl_t               o_ctrl
);

    always_comb begin
        o_ctrl = '0;   // Inactive unless decoded below
        if (i_enable) begin
            case (i_opcode)
                mips_isa_pkg::OP_RTYPE: begin
                    o_ctrl.reg_dest  = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.alu_op    = mips_isa_pkg::ALU_FUNCT;
                end
                mips_isa_pkg::OP_ADDI: begin
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.alu_op    = mips_isa_pkg::ALU_ADD;
                end
                mips_isa_pkg::OP_LW: begin
                    o_ctrl.alu_src    = 1'b1;
                    o_ctrl.mem_read   = 1'b1;
                    o_ctrl.mem_to_reg = 1'b1;   // Load result goes to WB
                    o_ctrl.reg_write  = 1'b1;
                    o_ctrl.alu_op     = mips_isa_pkg::ALU_ADD;
                end
                mips_isa_pkg::OP_SW: begin
                    o_ctrl.alu_src   = 1'b1;
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.alu_op    = mips_isa_pkg::ALU_ADD;
                end
                mips_isa_pkg::OP_BEQ: begin
                    o_ctrl.branch = 1'b1;   // Resolved later in the pipe
                    o_ctrl.alu_op = mips_isa_pkg::ALU_SUB;
                end
                mips_isa_pkg::OP_J: begin
                    o_ctrl.jump = 1'b1;
                end
                default: begin
                    o_ctrl = '0;   // Unknown opcode
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                                  i_clock,
    input  wire                                  i_reset,
    input  wire                                  i_stall,
    input  wire                                  i_jump,          // From ID, valid jump in IF/ID
    input  wire  [mips_isa_pkg::WORD_W-1:0]      i_jump_address,
    input  wire  [mips_isa_pkg::WORD_W-1:0]      i_wb_dat,
    input  wire                                  i_wb_ack,
    output logic                                 o_wb_cyc,
    output logic                                 o_wb_stb,
    output logic [mips_isa_pkg::WORD_W-1:0]      o_wb_adr,
    output logic                                 o_wb_we,
    output pipe_pkg::if_id_t                     o_if_id
);

    typedef enum logic {
        IDLE,
        BUS
    } state_e;

    state_e                          state;
    logic [mips_isa_pkg::WORD_W-1:0] pc;             // Address of the next fetch
    logic                            jump_pending;   // Redirect waits for the delay slot
    logic [mips_isa_pkg::WORD_W-1:0] jump_target;
    logic                            bus_done;

    assign bus_done = (state == BUS) && i_wb_ack;
    assign o_wb_cyc = (state == BUS);
    assign o_wb_stb = (state == BUS);
    assign o_wb_adr = pc;
    assign o_wb_we  = 1'b0;   // Read-only master

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= i_stall ? IDLE : BUS;
                BUS:     state <= i_wb_ack ? IDLE : BUS;   // Drop for a cycle after ack
                default: state <= IDLE;
            endcase
        end
    end

    // The word completing while a jump is pending is the delay slot
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc           <= mips_isa_pkg::RESET_PC;
            jump_pending <= 1'b0;
        end else if (bus_done) begin
            pc           <= jump_pending ? jump_target : pc + mips_isa_pkg::PC_STEP;
            jump_pending <= 1'b0;
        end else if (i_jump) begin
            jump_pending <= 1'b1;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_jump) begin
            jump_target <= i_jump_address;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_if_id.valid <= 1'b0;
        end else if (bus_done) begin
            o_if_id.valid <= 1'b1;
            o_if_id.pc    <= pc;
            o_if_id.inst  <= i_wb_dat;
        end else if (!i_stall) begin
            o_if_id.valid <= 1'b0;   // Consumed by ID
        end
    end

endmodule

`default_nettype wire

//--- rtl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                                  i_clock,
    input  wire                                  i_reset,
    input  wire                                  i_stall,
    input  wire  pipe_pkg::if_id_t               i_if_id,
    input  wire  pipe_pkg::wb_write_t            i_wb,
    output logic                                 o_jump,
    output logic [mips_isa_pkg::WORD_W-1:0]      o_jump_address,
    output pipe_pkg::id_ex_t                     o_id_ex
);

    logic [mips_isa_pkg::WORD_W-1:0]     inst;
    mips_isa_pkg::opcode_e               opcode;
    logic [mips_isa_pkg::REG_ADDR_W-1:0] rs;
    logic [mips_isa_pkg::REG_ADDR_W-1:0] rt;
    logic [mips_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [mips_isa_pkg::IMM_W-1:0]      imm;
    logic [mips_isa_pkg::WORD_W-1:0]     imm_ext;
    logic [mips_isa_pkg::WORD_W-1:0]     pc_plus4;
    logic [mips_isa_pkg::WORD_W-1:0]     data_a;
    logic [mips_isa_pkg::WORD_W-1:0]     data_b;
    pipe_pkg::ctrl_t                     ctrl;

    assign inst   = i_if_id.inst;
    assign opcode = mips_isa_pkg::opcode_e'(inst[mips_isa_pkg::OP_LSB +: mips_isa_pkg::OPCODE_W]);
    assign rs     = inst[mips_isa_pkg::RS_LSB +: mips_isa_pkg::REG_ADDR_W];
    assign rt     = inst[mips_isa_pkg::RT_LSB +: mips_isa_pkg::REG_ADDR_W];
    assign rd     = inst[mips_isa_pkg::RD_LSB +: mips_isa_pkg::REG_ADDR_W];
    assign imm    = inst[mips_isa_pkg::IMM_W-1:0];

    assign imm_ext  = {{(mips_isa_pkg::WORD_W - mips_isa_pkg::IMM_W){imm[mips_isa_pkg::IMM_W-1]}}, imm};
    assign pc_plus4 = i_if_id.pc + mips_isa_pkg::PC_STEP;

    // Region bits of PC+4, then the word index
    assign o_jump_address = {pc_plus4[mips_isa_pkg::WORD_W-1 -: mips_isa_pkg::JUMP_HI_W],
                             inst[mips_isa_pkg::JIDX_W-1:0], 2'b00};
    assign o_jump         = ctrl.jump;   // Already gated by IF/ID valid

    registers_bank u_registers_bank (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_read_reg_a (rs),
        .i_read_reg_b (rt),
        .i_wb         (i_wb),
        .o_data_a     (data_a),
        .o_data_b     (data_b)
    );

    control_unit u_control_unit (
        .i_enable (i_if_id.valid),
        .i_opcode (opcode),
        .o_ctrl   (ctrl)
    );

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_id_ex <= '0;
        end else if (i_stall) begin
            o_id_ex.valid <= 1'b0;   // Payload held, pulse not repeated
        end else begin
            o_id_ex.valid        <= i_if_id.valid;
            o_id_ex.ctrl         <= ctrl;
            o_id_ex.pc           <= i_if_id.pc;
            o_id_ex.data_a       <= data_a;
            o_id_ex.data_b       <= data_b;
            o_id_ex.immediate    <= imm_ext;
            o_id_ex.rt           <= rt;
            o_id_ex.rd           <= rd;
            o_id_ex.jump_address <= o_jump_address;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_front_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_front_top (
    input  wire                                  i_clock,
    input  wire                                  i_reset,
    input  wire                                  i_stall,
    input  wire  [mips_isa_pkg::WORD_W-1:0]      i_wb_dat,
    input  wire                                  i_wb_ack,
    input  wire  pipe_pkg::wb_write_t            i_wb_write,   // Writeback into the bank
    output logic                                 o_wb_cyc,
    output logic                                 o_wb_stb,
    output logic [mips_isa_pkg::WORD_W-1:0]      o_wb_adr,
    output logic                                 o_wb_we,
    output pipe_pkg::id_ex_t                     o_id_ex
);

    pipe_pkg::if_id_t                if_id;
    logic                            jump;
    logic [mips_isa_pkg::WORD_W-1:0] jump_address;

    fetch_unit u_fetch_unit (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_jump         (jump),
        .i_jump_address (jump_address),
        .i_wb_dat       (i_wb_dat),
        .i_wb_ack       (i_wb_ack),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_adr       (o_wb_adr),
        .o_wb_we        (o_wb_we),
        .o_if_id        (if_id)
    );

    id_stage u_id_stage (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_if_id        (if_id),
        .i_wb           (i_wb_write),
        .o_jump         (jump),           // Back to fetch, same cycle
        .o_jump_address (jump_address),
        .o_id_ex        (o_id_ex)
    );

endmodule

`default_nettype wire

//--- rtl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // Architectural widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int OPCODE_W   = 6;
    localparam int IMM_W      = 16;                    // I-type immediate
    localparam int JIDX_W     = 26;                    // J-type word index
    localparam int JUMP_HI_W  = WORD_W - JIDX_W - 2;   // PC+4 bits kept on a jump

    // Instruction field positions (low bit of each field)
    localparam int OP_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;

    localparam logic [WORD_W-1:0] RESET_PC = 32'h0000_0000;   // First fetch address
    localparam logic [WORD_W-1:0] PC_STEP  = 32'd4;           // One word

    // Primary opcodes handled by the decoder
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    // Operation requested from EX
    typedef enum logic [1:0] {
        ALU_NONE  = 2'd0,   // Bubble or jump
        ALU_ADD   = 2'd1,   // Address calc or addi
        ALU_SUB   = 2'd2,   // beq compare
        ALU_FUNCT = 2'd3    // R-type, EX looks at funct
    } alu_op_e;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Control bits carried from ID down to EX, MEM and WB
    typedef struct packed {
        logic                  reg_dest;     // EX, rd instead of rt
        mips_isa_pkg::alu_op_e alu_op;       // EX
        logic                  alu_src;      // EX, immediate as operand B
        logic                  mem_read;     // MEM
        logic                  mem_write;    // MEM
        logic                  branch;       // MEM
        logic                  reg_write;    // WB
        logic                  mem_to_reg;   // WB
        logic                  jump;         // ID, fetch redirect
    } ctrl_t;

    // Fetched word and its address
    typedef struct packed {
        logic                              valid;
        logic [mips_isa_pkg::WORD_W-1:0]   pc;
        logic [mips_isa_pkg::WORD_W-1:0]   inst;
    } if_id_t;

    // Decode results handed to EX
    typedef struct packed {
        logic                                valid;
        ctrl_t                               ctrl;
        logic [mips_isa_pkg::WORD_W-1:0]     pc;
        logic [mips_isa_pkg::WORD_W-1:0]     data_a;
        logic [mips_isa_pkg::WORD_W-1:0]     data_b;
        logic [mips_isa_pkg::WORD_W-1:0]     immediate;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rt;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [mips_isa_pkg::WORD_W-1:0]     jump_address;
    } id_ex_t;

    // Register bank write port, driven from WB
    typedef struct packed {
        logic                                reg_write;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] write_reg;
        logic [mips_isa_pkg::WORD_W-1:0]     write_data;
    } wb_write_t;

endpackage

`default_nettype wire

//--- rtl/registers_bank.sv
`timescale 1ns/1ps
`default_nettype none

module registers_bank (
    input  wire                                      i_clock,
    input  wire                                      i_reset,
    input  wire  [mips_isa_pkg::REG_ADDR_W-1:0]      i_read_reg_a,
    input  wire  [mips_isa_pkg::REG_ADDR_W-1:0]      i_read_reg_b,
    input  wire  pipe_pkg::wb_write_t                i_wb,
    output logic [mips_isa_pkg::WORD_W-1:0]          o_data_a,
    output logic [mips_isa_pkg::WORD_W-1:0]          o_data_b
);

    logic [mips_isa_pkg::WORD_W-1:0]     regs    [mips_isa_pkg::NUM_REGS];
    logic [mips_isa_pkg::REG_ADDR_W-1:0] rd_addr [2];
    logic [mips_isa_pkg::WORD_W-1:0]     rd_data [2];

    assign rd_addr[0] = i_read_reg_a;
    assign rd_addr[1] = i_read_reg_b;
    assign o_data_a   = rd_data[0];
    assign o_data_b   = rd_data[1];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < mips_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.reg_write && (i_wb.write_reg != '0)) begin   // r0 stays zero
            regs[i_wb.write_reg] <= i_wb.write_data;
        end
    end

    // Both read ports share the same forwarding rule
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;
            end else if (i_wb.reg_write && (i_wb.write_reg == rd_addr[p])) begin
                rd_data[p] = i_wb.write_data;   // Write-through
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing \
    -f mips_front_top.f \
    --top-module mips_front_top_tb \
    --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
else
    exit 1
fi

//--- tests/mips_front_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_front_top_tb;

    logic                clock;
    logic                reset;
    logic                stall;
    logic [31:0]         wb_dat;
    logic                wb_ack;
    pipe_pkg::wb_write_t wb_write;
    logic                wb_cyc;
    logic                wb_stb;
    logic [31:0]         wb_adr;
    logic                wb_we;
    pipe_pkg::id_ex_t    id_ex;

    logic [31:0] mem [256];       // Word array, index is adr[9:2]
    logic [31:0] ref_regs [32];
    logic [15:0] lfsr = 16'd23;
    logic [31:0] seen_pcs [$];
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    pipe_pkg::ctrl_t exp_ctrl;
    logic [31:0] saved_target;
    logic        jump_armed;
    logic        cyc_prev;
    logic        ack_prev;
    logic [31:0] first_adr;
    int          wait_cnt;
    int          pulses;
    int          starts;
    int          value_errors;
    int          timeouts;

    mips_front_top i_dut (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_stall    (stall),
        .i_wb_dat   (wb_dat),
        .i_wb_ack   (wb_ack),
        .i_wb_write (wb_write),
        .o_wb_cyc   (wb_cyc),
        .o_wb_stb   (wb_stb),
        .o_wb_adr   (wb_adr),
        .o_wb_we    (wb_we),
        .o_id_ex    (id_ex)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Region of PC+4 joined with the word index
    function automatic logic [31:0] jump_target_of(input logic [31:0] pc,
                                                   input logic [31:0] inst);
        logic [31:0] next_pc;
        next_pc = pc + 32'd4;
        return {next_pc[31:28], inst[25:0], 2'b00};
    endfunction

    // Control table per opcode
    function automatic pipe_pkg::ctrl_t ref_ctrl(input logic [5:0] op);
        pipe_pkg::ctrl_t c;
        c = '0;
        case (op)
            6'd0: begin
                c.reg_dest  = 1'b1;
                c.reg_write = 1'b1;
                c.alu_op    = mips_isa_pkg::ALU_FUNCT;
            end
            6'd8: begin
                c.alu_src   = 1'b1;
                c.reg_write = 1'b1;
                c.alu_op    = mips_isa_pkg::ALU_ADD;
            end
            6'd35: begin
                c.alu_src    = 1'b1;
                c.mem_read   = 1'b1;
                c.mem_to_reg = 1'b1;
                c.reg_write  = 1'b1;
                c.alu_op     = mips_isa_pkg::ALU_ADD;
            end
            6'd43: begin
                c.alu_src   = 1'b1;
                c.mem_write = 1'b1;
                c.alu_op    = mips_isa_pkg::ALU_ADD;
            end
            6'd4: begin
                c.branch = 1'b1;
                c.alu_op = mips_isa_pkg::ALU_SUB;
            end
            6'd2:    c.jump = 1'b1;
            default: c = '0;
        endcase
        return c;
    endfunction

    // Wishbone memory with 0 to 3 wait cycles
    always @(posedge clock) begin
        if (reset || wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_cnt == 0) begin
                wb_ack   <= 1'b1;
                wb_dat   <= mem[wb_adr[9:2]];
                wait_cnt <= rand_bits(2);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // Bus rules, scoreboard and the reference register file
    always @(posedge clock) begin
        if (!reset) begin
            assert (wb_cyc == wb_stb && !wb_we) else begin
                value_errors++;
                $display("[ERROR] %0t: cyc/stb mismatch or we high", $time);
            end
            assert (!(cyc_prev && !ack_prev) || wb_cyc) else begin
                value_errors++;
                $display("[ERROR] %0t: cyc dropped before ack", $time);
            end
            if (wb_cyc && !cyc_prev) begin
                if (starts == 0) first_adr = wb_adr;
                starts++;
            end
            if (id_ex.valid) begin
                exp_inst = mem[exp_pc[9:2]];
                exp_ctrl = ref_ctrl(exp_inst[31:26]);
                assert (id_ex.pc == exp_pc
                        && id_ex.ctrl == exp_ctrl
                        && id_ex.immediate == {{16{exp_inst[15]}}, exp_inst[15:0]}
                        && id_ex.rt == exp_inst[20:16]
                        && id_ex.rd == exp_inst[15:11]
                        && id_ex.data_a == ref_regs[exp_inst[25:21]]
                        && id_ex.data_b == ref_regs[exp_inst[20:16]]
                        && id_ex.jump_address == jump_target_of(exp_pc, exp_inst)) else begin
                    value_errors++;
                    $display("[ERROR] %0t: ID/EX pc %h, expected pc %h inst %h", $time,
                             id_ex.pc, exp_pc, exp_inst);
                end
                seen_pcs.push_back(id_ex.pc);
                pulses++;
                if (exp_ctrl.jump) begin
                    saved_target = jump_target_of(exp_pc, exp_inst);
                    jump_armed   = 1'b1;
                    exp_pc       = exp_pc + 32'd4;      // Delay slot comes next
                end else if (jump_armed) begin
                    jump_armed = 1'b0;
                    exp_pc     = saved_target;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
            end
            if (wb_write.reg_write && wb_write.write_reg != 5'd0) begin
                ref_regs[wb_write.write_reg] = wb_write.write_data;   // Commits at this edge
            end
        end
        cyc_prev = wb_cyc;
        ack_prev = wb_ack;
    end

    task automatic wait_pulses(input int target);
        int n;
        n = 0;
        while (pulses < target && n < 400) begin
            @(negedge clock);
            n++;
        end
        if (pulses < target) begin
            timeouts++;
            $display("Timeout: only %0d of %0d decoded instructions arrived", pulses, target);
        end
    endtask

    task automatic check_reset_and_sequence();
        wait_pulses(3);
        assert (first_adr == 32'h0 && seen_pcs.size() >= 3 && seen_pcs[0] == 32'h0
                && seen_pcs[1] == 32'h4 && seen_pcs[2] == 32'h8) else begin
            value_errors++;
            $display("[ERROR] %0t: first fetch %h or sequence 0,4,8 wrong", $time, first_adr);
        end
    endtask

    task automatic check_decode_program();
        wait_pulses(8);   // Scoreboard holds the per-opcode comparison
    endtask

    task automatic check_jump_delay_slot();
        wait_pulses(9);
        assert (seen_pcs.size() >= 9 && seen_pcs[6] == 32'h18 && seen_pcs[7] == 32'h1C
                && seen_pcs[8] == 32'h100) else begin
            value_errors++;
            $display("[ERROR] %0t: jump, delay slot, target order wrong", $time);
        end
    endtask

    task automatic check_writeback_regs(input int cycles);
        logic [31:0] inst;
        logic [31:0] data;
        for (int k = 0; k < cycles; k++) begin
            @(negedge clock);
            inst = mem[exp_pc[9:2]];   // Word decoded next
            data = rand_bits(32);
            @(posedge clock);
            wb_write.reg_write  <= 1'b1;
            wb_write.write_reg  <= (k % 3 == 0) ? 5'd0 : (k % 2 == 1) ? inst[25:21] : inst[20:16];
            wb_write.write_data <= data;
        end
        @(posedge clock);
        wb_write.reg_write <= 1'b0;
        wait_pulses(pulses + 4);
    endtask

    task automatic check_stall();
        int len;
        int snap;
        int n;
        len = 3 + int'(rand_bits(3));
        n   = 0;
        while (!wb_cyc && n < 50) begin
            @(negedge clock);
            n++;
        end
        if (!wb_cyc) begin
            timeouts++;
            $display("Timeout: no bus request seen before the stall");
        end
        @(posedge clock);
        stall <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        snap = starts;
        repeat (len) @(posedge clock);
        @(negedge clock);
        assert (starts == snap) else begin
            value_errors++;
            $display("[ERROR] %0t: bus request started during stall", $time);
        end
        @(posedge clock);
        stall <= 1'b0;
        wait_pulses(pulses + 4);
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {6'd8, 5'(i) ^ 5'h3, 5'(i >> 2), 16'h8000 | 16'(i * 7)};
        end
        mem[0] = {6'd0, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20};    // add r3,r1,r2
        mem[1] = {6'd8, 5'd5, 5'd4, 16'hFFF8};             // addi r4,r5,-8
        mem[2] = {6'd35, 5'd7, 5'd6, 16'd12};              // lw r6,12(r7)
        mem[3] = {6'd43, 5'd1, 5'd2, 16'hFFFC};            // sw r2,-4(r1)
        mem[4] = {6'd4, 5'd1, 5'd2, 16'd3};                // beq
        mem[5] = {6'd63, 26'h123_4567};                    // Unknown opcode
        mem[6] = {6'd2, 26'h40};                           // j 0x100
        mem[7] = {6'd8, 5'd0, 5'd1, 16'h0011};             // Delay slot
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        reset        = 1'b1;
        stall        = 1'b0;
        wb_dat       = '0;
        wb_ack       = 1'b0;
        wb_write     = '0;
        exp_pc       = '0;
        exp_inst     = '0;
        exp_ctrl     = '0;
        saved_target = '0;
        jump_armed   = 1'b0;
        cyc_prev     = 1'b0;
        ack_prev     = 1'b0;
        first_adr    = 32'hFFFF_FFFF;
        wait_cnt     = 0;
        pulses       = 0;
        starts       = 0;
        value_errors = 0;
        timeouts     = 0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        check_reset_and_sequence();
        if (timeouts == 0) check_decode_program();
        if (timeouts == 0) check_jump_delay_slot();
        if (timeouts == 0) check_writeback_regs(30);
        if (timeouts == 0) check_stall();
        if (timeouts == 0) check_stall();
        $display("Errors: %0d value, %0d timeout", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
